// ==== src/spi_xip_pkg.sv ====
package spi_xip_pkg;

  // Flash window, every read becomes one XIP sequence
  localparam logic [31:0] FLASH_BASE = 32'h3000_0000;
  localparam logic [31:0] FLASH_END  = 32'h3fff_ffff;

  // Direct window onto the SPI master registers
  localparam logic [31:0] SPI_BASE = 32'h1000_1000;
  localparam logic [31:0] SPI_END  = 32'h1000_1fff;

  // Slave-select lines driven by the SS register
  localparam int SS_NUM = 8;

  // Flash read opcode, followed by 24 address bits
  localparam logic [7:0] XIP_CMD_READ = 8'h03;

  // GO on write, BUSY on read
  localparam int CTRL_GO_BIT = 8;

  // Transfer setup written by the sequencer
  localparam int          XIP_CHAR_LEN = 64;
  localparam logic [15:0] XIP_DIVIDER  = 16'd1;

  // Register byte offsets inside the SPI window
  typedef enum logic [4:0] {
    REG_DATA0   = 5'h00,  // RX0 / TX0
    REG_DATA1   = 5'h04,  // RX1 / TX1
    REG_CTRL    = 5'h10,
    REG_DIVIDER = 5'h14,
    REG_SS      = 5'h18
  } reg_off_e;

  // Internal register bus, request side
  typedef struct packed {
    logic        valid;
    logic        write;
    reg_off_e    addr;
    logic [3:0]  sel;
    logic [31:0] wdata;
  } reg_req_t;

  // Response, one cycle after the request is first seen
  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] rdata;
  } reg_rsp_t;

  // XIP sequence steps
  typedef enum logic [2:0] {
    IDLE,
    SEND_CMD,
    SET_DIVIDER,
    SET_SS,
    GO_BUSY,
    WAIT_COMPLETE,
    READ_DATA,
    RELEASE_SS
  } xip_state_e;

endpackage

// ==== src/spi_shift_engine.sv ====
module spi_shift_engine (
  input  logic                           clock,
  input  logic                           reset,
  input  spi_xip_pkg::reg_req_t          req_i,
  output spi_xip_pkg::reg_rsp_t          rsp_o,
  output logic                           sck_o,
  output logic [spi_xip_pkg::SS_NUM-1:0] ss_o,
  output logic                           mosi_o,
  input  logic                           miso_i
);
  import spi_xip_pkg::*;

  // Merge the enabled byte lanes of a write into the old value
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  sel);
    logic [31:0] result;
    result = old_val;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) begin
        result[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return result;
  endfunction

  // Char length 0 stands for 64, longer values clamp to the register
  function automatic logic [6:0] len_of(input logic [6:0] len);
    return (len == 7'd0 || len > 7'd64) ? 7'd64 : len;
  endfunction

  logic [63:0]       shift_q;
  logic [6:0]        char_len_q;
  logic              busy_q;
  logic [15:0]       divider_q;
  logic [SS_NUM-1:0] ss_q;
  logic [15:0]       clk_cnt_q;
  logic [6:0]        bits_left_q;
  logic              sck_q;
  logic              mosi_hold_q;
  logic [5:0]        msb_idx;
  logic              new_access;
  logic              known_off;
  logic              wr_en;
  logic              idle_shift;
  logic [31:0]       rdata;
  logic [31:0]       wr_img;

  // A request is new unless it is being answered this cycle
  assign new_access = req_i.valid && !rsp_o.ack && !rsp_o.err;
  assign wr_en      = new_access && req_i.write && known_off;
  assign idle_shift = !busy_q && !sck_q;
  assign msb_idx    = 6'(len_of(char_len_q) - 7'd1);

  // Current image of the addressed register, also the base for writes
  always_comb begin
    rdata     = '0;
    known_off = 1'b1;
    case (req_i.addr)
      REG_DATA0:   rdata = shift_q[31:0];
      REG_DATA1:   rdata = shift_q[63:32];
      REG_CTRL: begin
        rdata[6:0]         = char_len_q;
        rdata[CTRL_GO_BIT] = busy_q;
      end
      REG_DIVIDER: rdata = {16'h0000, divider_q};
      REG_SS:      rdata = 32'(ss_q);
      default:     known_off = 1'b0;
    endcase
    wr_img = merge_bytes(rdata, req_i.wdata, req_i.sel);
  end

  // Registered ack or err, exactly one cycle per request
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rsp_o <= '0;
    end else begin
      rsp_o.ack <= new_access && known_off;
      rsp_o.err <= new_access && !known_off;
      if (new_access) begin
        rsp_o.rdata <= rdata;
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      shift_q     <= '0;
      char_len_q  <= '0;
      busy_q      <= 1'b0;
      divider_q   <= '0;
      ss_q        <= '0;
      clk_cnt_q   <= '0;
      bits_left_q <= '0;
      sck_q       <= 1'b0;
      mosi_hold_q <= 1'b0;
    end else begin
      // Data and CTRL frozen while a transfer runs
      if (wr_en) begin
        case (req_i.addr)
          REG_DATA0: begin
            if (idle_shift) begin
              shift_q[31:0] <= wr_img;
            end
          end
          REG_DATA1: begin
            if (idle_shift) begin
              shift_q[63:32] <= wr_img;
            end
          end
          REG_CTRL: begin
            if (idle_shift) begin
              char_len_q <= wr_img[6:0];
              if (wr_img[CTRL_GO_BIT]) begin
                busy_q      <= 1'b1;
                bits_left_q <= len_of(wr_img[6:0]);
                clk_cnt_q   <= '0;
              end
            end
          end
          REG_DIVIDER: divider_q <= wr_img[15:0];
          REG_SS:      ss_q      <= wr_img[SS_NUM-1:0];
          default:     ;
        endcase
      end
      // Keep running after the last sample until sck is low again
      if (busy_q || sck_q) begin
        if (clk_cnt_q >= divider_q) begin
          clk_cnt_q <= '0;
          sck_q     <= !sck_q;
          if (!sck_q) begin
            // Rising edge, sample MISO into the bottom
            shift_q     <= {shift_q[62:0], miso_i};
            mosi_hold_q <= shift_q[msb_idx];
            bits_left_q <= bits_left_q - 7'd1;
            if (bits_left_q == 7'd1) begin
              busy_q <= 1'b0;
            end
          end
        end else begin
          clk_cnt_q <= clk_cnt_q + 16'd1;
        end
      end
    end
  end

  // Hold the sent bit through the high phase, next bit after the fall
  assign mosi_o = sck_q ? mosi_hold_q : shift_q[msb_idx];
  assign sck_o  = sck_q;
  assign ss_o   = ~ss_q;

endmodule

// ==== src/reg_bus_arbiter.sv ====
module reg_bus_arbiter (
  input  logic                  clock,
  input  logic                  reset,
  input  spi_xip_pkg::reg_req_t xip_req_i,
  output spi_xip_pkg::reg_rsp_t xip_rsp_o,
  input  spi_xip_pkg::reg_req_t apb_req_i,
  output spi_xip_pkg::reg_rsp_t apb_rsp_o,
  output spi_xip_pkg::reg_req_t eng_req_o,
  input  spi_xip_pkg::reg_rsp_t eng_rsp_i
);

  logic locked_q;
  logic owner_xip_q;
  logic grant_xip;

  // Sequencer wins when the bus is free, owner kept while locked
  assign grant_xip = locked_q ? owner_xip_q : xip_req_i.valid;

  // Plain forwarding, no added latency
  assign eng_req_o = grant_xip ? xip_req_i : apb_req_i;

  // Loser sees ack low and keeps its request up
  assign xip_rsp_o = grant_xip ? eng_rsp_i : '0;
  assign apb_rsp_o = grant_xip ? '0 : eng_rsp_i;

  // Lock from first valid cycle through the ack cycle
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      locked_q    <= 1'b0;
      owner_xip_q <= 1'b0;
    end else if (eng_rsp_i.ack || eng_rsp_i.err) begin
      locked_q <= 1'b0;
    end else if (!locked_q && eng_req_o.valid) begin
      locked_q    <= 1'b1;
      owner_xip_q <= grant_xip;
    end
  end

endmodule

// ==== src/xip_sequencer.sv ====
module xip_sequencer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start_i,
  input  logic [23:0]           addr_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic [31:0]           data_o,
  output spi_xip_pkg::reg_req_t req_o,
  input  spi_xip_pkg::reg_rsp_t rsp_i
);
  import spi_xip_pkg::*;

  xip_state_e  state_q;
  logic [23:0] addr_q;

  // Busy until the SS release has been acknowledged
  assign busy_o = (state_q != IDLE);

  // One register access per state, held until ack
  always_comb begin
    req_o       = '0;
    req_o.valid = (state_q != IDLE);
    req_o.sel   = 4'hf;
    req_o.addr  = REG_DATA0;
    case (state_q)
      SEND_CMD: begin
        // Command byte on top, address below
        req_o.write = 1'b1;
        req_o.addr  = REG_DATA1;
        req_o.wdata = {XIP_CMD_READ, addr_q};
      end
      SET_DIVIDER: begin
        req_o.write = 1'b1;
        req_o.addr  = REG_DIVIDER;
        req_o.wdata = 32'(XIP_DIVIDER);
      end
      SET_SS: begin
        // Flash sits on slave-select 0
        req_o.write = 1'b1;
        req_o.addr  = REG_SS;
        req_o.wdata = 32'd1;
      end
      GO_BUSY: begin
        req_o.write = 1'b1;
        req_o.addr  = REG_CTRL;
        req_o.wdata = (32'd1 << CTRL_GO_BIT) | 32'(XIP_CHAR_LEN);
      end
      WAIT_COMPLETE: begin
        // Poll BUSY
        req_o.addr = REG_CTRL;
      end
      READ_DATA: begin
        // Last 32 bits received land in RX0
        req_o.addr = REG_DATA0;
      end
      RELEASE_SS: begin
        req_o.write = 1'b1;
        req_o.addr  = REG_SS;
        req_o.wdata = 32'd0;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= IDLE;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= SEND_CMD;
          end
        end
        SEND_CMD: begin
          if (rsp_i.ack) begin
            state_q <= SET_DIVIDER;
          end
        end
        SET_DIVIDER: begin
          if (rsp_i.ack) begin
            state_q <= SET_SS;
          end
        end
        SET_SS: begin
          if (rsp_i.ack) begin
            state_q <= GO_BUSY;
          end
        end
        GO_BUSY: begin
          if (rsp_i.ack) begin
            state_q <= WAIT_COMPLETE;
          end
        end
        WAIT_COMPLETE: begin
          // Reissue the CTRL read while BUSY is still set
          if (rsp_i.ack && !rsp_i.rdata[CTRL_GO_BIT]) begin
            state_q <= READ_DATA;
          end
        end
        READ_DATA: begin
          // Word goes out now, SS release follows
          if (rsp_i.ack) begin
            done_o  <= 1'b1;
            state_q <= RELEASE_SS;
          end
        end
        RELEASE_SS: begin
          if (rsp_i.ack) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Address and result word
  always_ff @(posedge clock) begin
    if (state_q == IDLE && start_i) begin
      addr_q <= addr_i;
    end
    if (state_q == READ_DATA && rsp_i.ack) begin
      data_o <= rsp_i.rdata;
    end
  end

endmodule

// ==== src/apb_front.sv ====
module apb_front (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [31:0]           paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [31:0]           pwdata_i,
  input  logic [3:0]            pstrb_i,
  output logic                  pready_o,
  output logic [31:0]           prdata_o,
  output logic                  pslverr_o,
  output spi_xip_pkg::reg_req_t req_o,
  input  spi_xip_pkg::reg_rsp_t rsp_i,
  output logic                  xip_start_o,
  output logic [23:0]           xip_addr_o,
  input  logic                  xip_busy_i,
  input  logic                  xip_done_i,
  input  logic [31:0]           xip_data_i
);
  import spi_xip_pkg::*;

  logic in_flash;
  logic in_spi;
  logic access;
  logic flash_rd;
  logic bad;
  logic launched_q;

  // Window decode
  assign in_flash = (paddr_i >= FLASH_BASE) && (paddr_i <= FLASH_END);
  assign in_spi   = (paddr_i >= SPI_BASE) && (paddr_i <= SPI_END);
  assign access   = psel_i && penable_i;
  assign flash_rd = access && in_flash && !pwrite_i;

  // Direct request straight from the held APB access phase
  always_comb begin
    req_o       = '0;
    req_o.valid = access && in_spi;
    req_o.write = pwrite_i;
    req_o.addr  = reg_off_e'(paddr_i[4:0]);
    req_o.sel   = pstrb_i;
    req_o.wdata = pwdata_i;
  end

  // One launch per APB transfer
  assign xip_start_o = flash_rd && !launched_q && !xip_busy_i;
  assign xip_addr_o  = paddr_i[23:0];

  // Flash write, unmapped address, or SS release still pending
  assign bad = access && ((in_flash && pwrite_i) || (!in_flash && !in_spi) ||
                          (flash_rd && !launched_q && xip_busy_i));

  assign pready_o  = (access && in_spi && (rsp_i.ack || rsp_i.err)) ||
                     (launched_q && xip_done_i) || bad;
  assign pslverr_o = (access && in_spi && rsp_i.err) || bad;
  assign prdata_o  = in_flash ? xip_data_i : rsp_i.rdata;

  // Set at launch, cleared by the returned word
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      launched_q <= 1'b0;
    end else if (xip_start_o) begin
      launched_q <= 1'b1;
    end else if (xip_done_i) begin
      launched_q <= 1'b0;
    end
  end

endmodule

// ==== src/spi_xip_top.sv ====
module spi_xip_top (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [31:0]                    paddr_i,
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  logic [31:0]                    pwdata_i,
  input  logic [3:0]                     pstrb_i,
  output logic                           pready_o,
  output logic [31:0]                    prdata_o,
  output logic                           pslverr_o,
  output logic                           spi_sck_o,
  output logic [spi_xip_pkg::SS_NUM-1:0] spi_ss_o,
  output logic                           spi_mosi_o,
  input  logic                           spi_miso_i
);
  import spi_xip_pkg::*;

  reg_req_t    apb_req;
  reg_rsp_t    apb_rsp;
  reg_req_t    xip_req;
  reg_rsp_t    xip_rsp;
  reg_req_t    eng_req;
  reg_rsp_t    eng_rsp;
  logic        xip_start;
  logic [23:0] xip_addr;
  logic        xip_busy;
  logic        xip_done;
  logic [31:0] xip_data;

  apb_front u_apb_front (
    .clock       (clock),
    .reset       (reset),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .pstrb_i     (pstrb_i),
    .pready_o    (pready_o),
    .prdata_o    (prdata_o),
    .pslverr_o   (pslverr_o),
    .req_o       (apb_req),
    .rsp_i       (apb_rsp),
    .xip_start_o (xip_start),
    .xip_addr_o  (xip_addr),
    .xip_busy_i  (xip_busy),
    .xip_done_i  (xip_done),
    .xip_data_i  (xip_data)
  );

  xip_sequencer u_xip_sequencer (
    .clock   (clock),
    .reset   (reset),
    .start_i (xip_start),
    .addr_i  (xip_addr),
    .busy_o  (xip_busy),
    .done_o  (xip_done),
    .data_o  (xip_data),
    .req_o   (xip_req),
    .rsp_i   (xip_rsp)
  );

  // Sequencer has priority on the shared register bus
  reg_bus_arbiter u_reg_bus_arbiter (
    .clock     (clock),
    .reset     (reset),
    .xip_req_i (xip_req),
    .xip_rsp_o (xip_rsp),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .eng_req_o (eng_req),
    .eng_rsp_i (eng_rsp)
  );

  spi_shift_engine u_spi_shift_engine (
    .clock  (clock),
    .reset  (reset),
    .req_i  (eng_req),
    .rsp_o  (eng_rsp),
    .sck_o  (spi_sck_o),
    .ss_o   (spi_ss_o),
    .mosi_o (spi_mosi_o),
    .miso_i (spi_miso_i)
  );

endmodule

// ==== verif/spi_flash_model.sv ====
module spi_flash_model (
  input  logic sck_i,
  input  logic ss_n_i,
  input  logic mosi_i,
  output logic miso_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int          error_count;
  logic [31:0] cmd_addr;
  logic [31:0] word;

  initial begin
    miso_o      = 1'b0;
    error_count = 0;
    cmd_addr    = '0;
    forever begin
      // New frame starts when the select line falls
      @(negedge ss_n_i);
      // Command byte and 24 address bits, sampled mid high phase
      for (int i = 0; i < 32; i++) begin
        @(posedge sck_i);
        #1;
        cmd_addr = {cmd_addr[30:0], mosi_i};
      end
      if (cmd_addr[31:24] != 8'h03) begin
        $display("Flash model got command byte %02h instead of the read command at %0t",
                 cmd_addr[31:24], $time);
        error_count++;
      end
      // Fixed data rule of the model
      word = {8'h5A, cmd_addr[23:0]} ^ 32'h0F0F_0F0F;
      // Mode 0, next bit goes out on each falling edge
      for (int i = 31; i >= 0; i--) begin
        @(negedge sck_i);
        miso_o = word[i];
      end
    end
  end

endmodule

// ==== verif/spi_xip_assert.sv ====
module spi_xip_assert (
  input logic                  clock,
  input logic                  reset,
  input logic                  sel_i,
  input logic                  enable_i,
  input logic                  ready_i,
  input spi_xip_pkg::reg_req_t req_i,
  input spi_xip_pkg::reg_rsp_t rsp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Ready only inside an access phase
  ready_in_access: assert property (@(posedge clock) disable iff (reset)
    ready_i |-> (sel_i && enable_i))
    else $error("ready high outside an access phase");

  // Request held unchanged until answered
  req_held: assert property (@(posedge clock) disable iff (reset)
    (req_i.valid && !rsp_i.ack && !rsp_i.err) |=> (req_i.valid && $stable(req_i)))
    else $error("register request dropped or changed before its ack");

  // Answer only while the request is still up
  rsp_to_requester: assert property (@(posedge clock) disable iff (reset)
    (rsp_i.ack || rsp_i.err) |-> req_i.valid)
    else $error("register response to a master without a pending request");

endmodule

// APB side of the front end
bind apb_front spi_xip_assert u_apb_assert (
  .clock    (clock),
  .reset    (reset),
  .sel_i    (psel_i),
  .enable_i (penable_i),
  .ready_i  (pready_o),
  .req_i    (req_o),
  .rsp_i    (rsp_i)
);

// Sequencer side of the arbiter, engine answer against the forwarded request
bind reg_bus_arbiter spi_xip_assert u_arb_assert (
  .clock    (clock),
  .reset    (reset),
  .sel_i    (eng_req_o.valid),
  .enable_i (1'b1),
  .ready_i  (eng_rsp_i.ack || eng_rsp_i.err),
  .req_i    (xip_req_i),
  .rsp_i    (xip_rsp_o)
);

// ==== verif/spi_xip_tb.sv ====
module spi_xip_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import spi_xip_pkg::*;

  typedef enum logic [2:0] {DIR_WRITE, DIR_READ, FLASH_READ, FLASH_WRITE, UNMAPPED} kind_e;

  // exp_data is the read value, or the register value after an SS write
  typedef struct packed {
    kind_e       kind;
    logic        rnd;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [31:0] exp_data;
    logic        exp_err;
  } entry_t;

  localparam int NUM_TESTS = 26;
  // Worst case flash read, 64 bits at 4 clocks plus register traffic
  localparam int CYCLES_PER_TEST = 64 * 4 + 64;
  localparam int WATCHDOG_NS = (NUM_TESTS * CYCLES_PER_TEST + 200) * 8;
  localparam logic [31:0] REGS = 32'h1000_1000;

  logic              clock;
  logic              reset;
  logic [31:0]       paddr_i;
  logic              psel_i;
  logic              penable_i;
  logic              pwrite_i;
  logic [31:0]       pwdata_i;
  logic [3:0]        pstrb_i;
  logic              pready_o;
  logic [31:0]       prdata_o;
  logic              pslverr_o;
  logic              spi_sck_o;
  logic [SS_NUM-1:0] spi_ss_o;
  logic              spi_mosi_o;
  logic              spi_miso_i;
  entry_t            tests [NUM_TESTS];
  logic [31:0]       lfsr_q;
  int                error_count = 0;
  int                sck_edges = 0;

  spi_xip_top DUT (.*);

  // Flash sits on slave-select 0
  spi_flash_model u_flash (
    .sck_i  (spi_sck_o),
    .ss_n_i (spi_ss_o[0]),
    .mosi_i (spi_mosi_o),
    .miso_o (spi_miso_i)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, an APB transfer never completed", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

  // SPI activity counter
  always @(posedge spi_sck_o) sck_edges++;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] flash_word(input logic [23:0] a);
    return {8'h5A, a} ^ 32'h0F0F_0F0F;
  endfunction

  function automatic int total_errors();
    return error_count + u_flash.error_count;
  endfunction

  // One LFSR step per address bit
  task automatic random_addr(output logic [23:0] a);
    for (int i = 0; i < 24; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      a = {a[22:0], lfsr_q[0]};
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %08h got %08h", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %0b got %0b", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_ss(input string name, input logic [SS_NUM-1:0] exp,
                          input logic [SS_NUM-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %02h got %02h", $time, name, exp, act);
      error_count++;
    end
  endtask

  // Called on a falling edge, returns on the falling edge after completion
  task automatic apb_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output logic err);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = data;
    pstrb_i   = strb;
    @(negedge clock);
    penable_i = 1'b1;
    // Let combinational pready settle
    #1;
    while (!pready_o) begin
      @(negedge clock);
      #1;
    end
    rdata = prdata_o;
    err   = pslverr_o;
    // Transfer ends on the next rising edge
    @(negedge clock);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  initial begin
    entry_t      t;
    logic [31:0] rdata;
    logic        err;
    logic        wr;
    logic [23:0] a24;
    int          errs_before;
    int          edges_before;
    reset     = 1'b1;
    paddr_i   = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    pwdata_i  = '0;
    pstrb_i   = '0;
    lfsr_q    = 32'hd350_6553;
    tests = '{
      // DIVIDER, full word then byte lane 0 only
      '{DIR_WRITE, 1'b0, REGS + 32'h14, 32'hABCD_1234, 4'hf, 32'h0, 1'b0},
      '{DIR_READ, 1'b0, REGS + 32'h14, 32'h0, 4'h0, 32'h0000_1234, 1'b0},
      '{DIR_WRITE, 1'b0, REGS + 32'h14, 32'hFFFF_FF56, 4'h1, 32'h0, 1'b0},
      '{DIR_READ, 1'b0, REGS + 32'h14, 32'h0, 4'h0, 32'h0000_1256, 1'b0},
      // SS keeps bit 0 clear so the flash stays deselected
      '{DIR_WRITE, 1'b0, REGS + 32'h18, 32'h1234_56A6, 4'hf, 32'h0000_00A6, 1'b0},
      '{DIR_READ, 1'b0, REGS + 32'h18, 32'h0, 4'h0, 32'h0000_00A6, 1'b0},
      '{DIR_WRITE, 1'b0, REGS + 32'h18, 32'hFFFF_FF00, 4'h2, 32'h0000_00A6, 1'b0},
      '{DIR_READ, 1'b0, REGS + 32'h18, 32'h0, 4'h0, 32'h0000_00A6, 1'b0},
      '{DIR_WRITE, 1'b0, REGS + 32'h04, 32'hDEAD_BEEF, 4'hf, 32'h0, 1'b0},
      '{DIR_WRITE, 1'b0, REGS + 32'h04, 32'h0000_1100, 4'h2, 32'h0, 1'b0},
      '{DIR_READ, 1'b0, REGS + 32'h04, 32'h0, 4'h0, 32'hDEAD_11EF, 1'b0},
      '{DIR_WRITE, 1'b0, REGS + 32'h18, 32'h0, 4'hf, 32'h0, 1'b0},
      '{FLASH_READ, 1'b0, 32'h3000_0000, 32'h0, 4'h0, 32'h550F_0F0F, 1'b0},
      // Sequencer setup visible right after the read
      '{DIR_READ, 1'b0, REGS + 32'h14, 32'h0, 4'h0, 32'h0000_0001, 1'b0},
      '{DIR_READ, 1'b0, REGS + 32'h18, 32'h0, 4'h0, 32'h0, 1'b0},
      '{FLASH_READ, 1'b0, 32'h3012_3456, 32'h0, 4'h0, 32'h551D_3B59, 1'b0},
      '{FLASH_READ, 1'b1, 32'h0, 32'h0, 4'h0, 32'h0, 1'b0},
      '{FLASH_READ, 1'b1, 32'h0, 32'h0, 4'h0, 32'h0, 1'b0},
      '{FLASH_READ, 1'b0, 32'h3FFF_FFFC, 32'h0, 4'h0, 32'h55F0_F0F3, 1'b0},
      '{FLASH_WRITE, 1'b0, 32'h3000_0100, 32'h1234_5678, 4'hf, 32'h0, 1'b1},
      '{UNMAPPED, 1'b0, 32'h2000_0000, 32'h0, 4'h0, 32'h0, 1'b1},
      '{UNMAPPED, 1'b0, 32'h1000_2000, 32'h0, 4'h0, 32'h0, 1'b1},
      // Offsets without a register
      '{DIR_READ, 1'b0, REGS + 32'h08, 32'h0, 4'h0, 32'h0, 1'b1},
      '{DIR_WRITE, 1'b0, REGS + 32'h1C, 32'hFFFF_FFFF, 4'hf, 32'h0, 1'b1},
      '{FLASH_READ, 1'b1, 32'h0, 32'h0, 4'h0, 32'h0, 1'b0},
      '{DIR_READ, 1'b0, REGS + 32'h18, 32'h0, 4'h0, 32'h0, 1'b0}
    };
    repeat (8) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    check_bit("pready_o", 1'b0, pready_o);
    check_bit("pslverr_o", 1'b0, pslverr_o);
    check_bit("spi_sck_o", 1'b0, spi_sck_o);
    check_ss("spi_ss_o", '1, spi_ss_o);
    for (int i = 0; i < NUM_TESTS; i++) begin
      t            = tests[i];
      errs_before  = total_errors();
      edges_before = sck_edges;
      wr = (t.kind == DIR_WRITE) || (t.kind == FLASH_WRITE);
      if (t.kind == FLASH_READ) begin
        // Previous SS release already done
        check_ss("spi_ss_o", '1, spi_ss_o);
        if (t.rnd) begin
          random_addr(a24);
          t.addr     = 32'h3000_0000 | {8'h00, a24};
          t.exp_data = flash_word(a24);
        end
      end
      apb_transfer(wr, t.addr, t.wdata, t.strb, rdata, err);
      check_bit("pslverr_o", t.exp_err, err);
      if (!wr && !t.exp_err) begin
        check_word("prdata_o", t.exp_data, rdata);
      end
      // SS pins are the inverted register
      if (t.kind == DIR_WRITE && t.addr[4:0] == 5'h18 && !t.exp_err) begin
        check_ss("spi_ss_o", ~t.exp_data[SS_NUM-1:0], spi_ss_o);
      end
      if (t.exp_err && sck_edges != edges_before) begin
        $display("SPI clock ran during rejected access %0d at %0t", i, $time);
        error_count++;
      end
      $display("test %0d %s addr %08h: %s", i, t.kind.name(), t.addr,
               (total_errors() == errs_before) ? "ok" : "error");
    end
    $display("Tests run %0d, errors %0d", NUM_TESTS, total_errors());
    if (total_errors() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== spi_xip.f ====
src/spi_xip_pkg.sv
src/spi_shift_engine.sv
src/reg_bus_arbiter.sv
src/xip_sequencer.sv
src/apb_front.sv
src/spi_xip_top.sv
verif/spi_flash_model.sv
verif/spi_xip_assert.sv
verif/spi_xip_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module spi_xip_tb -f spi_xip.f -o spi_xip_sim

status=0
./obj_dir/spi_xip_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Some tests failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
grep -q "All tests passed" sim.log
